// File: hdl/fp_norm_pkg.sv
`default_nettype none

package fp_norm_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int RAW_W   = 106;  // Raw product fraction
    localparam int FRACT_W = 53;   // Rounded fraction with hidden bit
    localparam int EXP_W   = 11;
    localparam int LZ_W    = 7;    // Holds 0 to 106

    // Special exponents
    localparam logic [EXP_W-1:0] EXP_INF = '1;
    localparam logic [EXP_W-1:0] EXP_MAX = EXP_INF - 1'b1;  // Largest finite

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [RAW_W-1:0]   raw_fract_t;
    typedef logic [FRACT_W-1:0] fract_t;
    typedef logic [EXP_W-1:0]   exp_t;
    typedef logic [LZ_W-1:0]    lz_t;

    // IEEE rounding direction
    typedef enum logic [1:0]
    {
        round_nearest = 2'd0,  // Ties to even
        round_zero    = 2'd1,
        round_up      = 2'd2,  // Toward plus infinity
        round_down    = 2'd3   // Toward minus infinity
    } round_mode_e;

endpackage

`default_nettype wire

// File: hdl/norm_bus.sv
`timescale 1ns/1ps
`default_nettype none

// Normalized operand on its way to the rounder
interface norm_bus;
    import fp_norm_pkg::*;

    raw_fract_t fract;    // Hidden bit at 104 unless denormal
    exp_t       exp;
    logic       denorm;
    logic       exp_ovf;  // Right shift pushed exponent out of range

    modport source
    (
        output fract, exp, denorm, exp_ovf
    );

    modport sink
    (
        input fract, exp, denorm, exp_ovf
    );

endinterface

`default_nettype wire

// File: hdl/lead_zero_count.sv
`timescale 1ns/1ps
`default_nettype none

module lead_zero_count
(
    input  wire fp_norm_pkg::raw_fract_t fract,
    output      fp_norm_pkg::lz_t        count
);
    import fp_norm_pkg::*;

    // Highest set bit wins
    always_comb
    begin
        count = lz_t'(RAW_W);  // All zero
        for (int i = 0; i < RAW_W; i++)
        begin
            if (fract[i])
                count = lz_t'(RAW_W - 1 - i);
        end
    end

endmodule

`default_nettype wire

// File: hdl/normalizer.sv
`timescale 1ns/1ps
`default_nettype none

module normalizer
(
    input  wire fp_norm_pkg::raw_fract_t fract_in,
    input  wire fp_norm_pkg::exp_t       exp_in,
    norm_bus.source                      out
);
    import fp_norm_pkg::*;

    lz_t  lz;
    exp_t lz_exp;    // Count widened to exponent width
    exp_t shift_l;   // Left shift amount
    logic limited;   // Exponent too small for a full left shift

    lead_zero_count u_lzc
    (
        .fract (fract_in),
        .count (lz)
    );

    assign lz_exp  = exp_t'(lz);
    assign limited = lz_exp > exp_in;

    // Stop at exponent 1 when the shift would underflow it
    assign shift_l = limited ? exp_in - 1'b1 : lz_exp - 1'b1;

    ////////////////////////////////////////////////////////////
    // Shift and exponent adjust
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        out.denorm = 1'b0;
        if (lz == lz_t'(0))
        begin
            // Product carried into bit 105
            out.fract = fract_in >> 1;
            out.exp   = exp_in + 1'b1;
        end
        else if (lz == lz_t'(1))
        begin
            out.fract = fract_in;
            out.exp   = exp_in;
        end
        else if (limited)
        begin
            out.fract  = fract_in << shift_l;
            out.exp    = exp_t'(1);
            out.denorm = 1'b1;
        end
        else
        begin
            out.fract = fract_in << shift_l;
            out.exp   = exp_in - shift_l;
        end
    end

    assign out.exp_ovf = (lz == lz_t'(0)) && (exp_in >= EXP_MAX);

    // Normal results must end up with the hidden bit in place
    always_comb
    begin
        if (!out.denorm && out.fract != '0)
        begin
            assert (out.fract[RAW_W-2])
            else
                $error("normalizer: hidden bit clear on a normal result");
        end
    end

endmodule

`default_nettype wire

// File: hdl/rounder.sv
`timescale 1ns/1ps
`default_nettype none

module rounder
(
    input  wire clk,
    input  wire reset,
    input  wire sign,
    input  wire fp_norm_pkg::round_mode_e r_mode,
    norm_bus.sink in,
    output fp_norm_pkg::fract_t fract_out,
    output fp_norm_pkg::exp_t   exp_out,
    output logic dn_out,
    output logic ine_out,
    output logic overflow_out,
    output logic infinite_out
);
    import fp_norm_pkg::*;

    fract_t fract_trunc;
    fract_t fract_inc;
    logic   carry;       // Increment ran out of the fraction
    logic   guard;
    logic   sticky;
    logic   inexact;
    logic   round_inc;
    fract_t fract_rnd;
    exp_t   exp_rnd;
    logic   overflow;
    logic   to_inf;
    fract_t fract_next;
    exp_t   exp_next;

    ////////////////////////////////////////////////////////////
    // Guard, sticky and increment decision
    ////////////////////////////////////////////////////////////

    assign fract_trunc = in.fract[RAW_W-2 -: FRACT_W];      // Bits 104..52
    assign guard       = in.fract[RAW_W-FRACT_W-2];         // Bit 51
    assign sticky      = |in.fract[RAW_W-FRACT_W-3:0];
    assign inexact     = guard | sticky;

    always_comb
    begin
        unique case (r_mode)
            round_nearest: round_inc = guard & (sticky | fract_trunc[0]);
            round_zero:    round_inc = 1'b0;
            round_up:      round_inc = inexact & ~sign;
            round_down:    round_inc = inexact & sign;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Increment with carry renormalization
    ////////////////////////////////////////////////////////////

    assign {carry, fract_inc} = {1'b0, fract_trunc} + 1'b1;

    always_comb
    begin
        fract_rnd = fract_trunc;
        exp_rnd   = in.exp;
        if (round_inc)
        begin
            // All ones rolled over to 1.000...
            fract_rnd = carry ? {carry, fract_inc[FRACT_W-1:1]} : fract_inc;
            exp_rnd   = in.exp + exp_t'(carry);
        end
    end

    ////////////////////////////////////////////////////////////
    // Overflow saturation
    ////////////////////////////////////////////////////////////

    assign overflow = in.exp_ovf | (round_inc & carry & (in.exp >= EXP_MAX));

    // Modes that round away from zero for this sign go to infinity
    assign to_inf = overflow &
                    ((r_mode == round_nearest) |
                     ((r_mode == round_up) & ~sign) |
                     ((r_mode == round_down) & sign));

    always_comb
    begin
        if (to_inf)
        begin
            fract_next = '0;
            exp_next   = EXP_INF;
        end
        else if (overflow)
        begin
            fract_next = '1;       // Largest finite
            exp_next   = EXP_MAX;
        end
        else
        begin
            fract_next = fract_rnd;
            exp_next   = exp_rnd;
        end
    end

    // Output stage
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fract_out    <= '0;
            exp_out      <= '0;
            dn_out       <= 1'b0;
            ine_out      <= 1'b0;
            overflow_out <= 1'b0;
            infinite_out <= 1'b0;
        end
        else
        begin
            fract_out    <= fract_next;
            exp_out      <= exp_next;
            dn_out       <= in.denorm;
            ine_out      <= inexact | overflow;
            overflow_out <= overflow;
            infinite_out <= to_inf;
        end
    end

    // A denormal cannot carry into a larger exponent
    a_denorm_exp: assert property (@(posedge clk) disable iff (reset)
        dn_out |-> exp_out == exp_t'(1))
    else
        $error("rounder: denormal result without exponent 1");

    a_hidden_bit: assert property (@(posedge clk) disable iff (reset)
        (!dn_out && fract_out != '0) |-> fract_out[FRACT_W-1])
    else
        $error("rounder: hidden bit clear on a normal result");

endmodule

`default_nettype wire

// File: hdl/norm_rnd.sv
`timescale 1ns/1ps
`default_nettype none

module norm_rnd
(
    input  wire clk,
    input  wire reset,
    input  wire fp_norm_pkg::raw_fract_t fract_in,
    input  wire fp_norm_pkg::exp_t       exp_in,
    input  wire sign,
    input  wire [1:0] r_mode,
    output fp_norm_pkg::fract_t fract_out,
    output fp_norm_pkg::exp_t   exp_out,
    output logic dn_out,
    output logic ine_out,
    output logic overflow_out,
    output logic infinite_out
);
    import fp_norm_pkg::*;

    norm_bus nb ();

    // Combinational normalize
    normalizer u_normalizer
    (
        .fract_in (fract_in),
        .exp_in   (exp_in),
        .out      (nb)
    );

    // Round and register
    rounder u_rounder
    (
        .clk          (clk),
        .reset        (reset),
        .sign         (sign),
        .r_mode       (round_mode_e'(r_mode)),
        .in           (nb),
        .fract_out    (fract_out),
        .exp_out      (exp_out),
        .dn_out       (dn_out),
        .ine_out      (ine_out),
        .overflow_out (overflow_out),
        .infinite_out (infinite_out)
    );

endmodule

`default_nettype wire

// File: include/norm_rnd_model.svh
`ifndef NORM_RND_MODEL_SVH
`define NORM_RND_MODEL_SVH

// Expected registered outputs for one operand
typedef struct packed {
    fp_norm_pkg::fract_t fract;
    fp_norm_pkg::exp_t   exp;
    logic                dn;
    logic                ine;
    logic                ovf;
    logic                inf;
} norm_rnd_result_t;

function automatic int model_lz(fp_norm_pkg::raw_fract_t f);
    int n;
    n = 0;
    while (n < fp_norm_pkg::RAW_W && !f[fp_norm_pkg::RAW_W - 1 - n])
        n++;
    return n;
endfunction

function automatic norm_rnd_result_t model_norm_rnd(fp_norm_pkg::raw_fract_t f,
                                                    fp_norm_pkg::exp_t e, logic sign,
                                                    fp_norm_pkg::round_mode_e mode);
    int                         lz;
    fp_norm_pkg::raw_fract_t    sh;
    fp_norm_pkg::exp_t          ex;
    logic [fp_norm_pkg::FRACT_W:0] sum;
    logic                       inc;
    logic                       carry;
    norm_rnd_result_t           r;
    lz = model_lz(f);
    r  = '0;
    if (lz == 0)
    begin
        sh = f >> 1;
        ex = e + 1'b1;
    end
    else if (lz == 1)
    begin
        sh = f;
        ex = e;
    end
    else if (lz <= e)
    begin
        sh = f << (lz - 1);
        ex = e - fp_norm_pkg::exp_t'(lz - 1);
    end
    else
    begin
        sh   = f << fp_norm_pkg::exp_t'(e - 1'b1);
        ex   = 1;
        r.dn = 1'b1;
    end
    case (mode)
        fp_norm_pkg::round_nearest: inc = sh[51] & ((|sh[50:0]) | sh[52]);
        fp_norm_pkg::round_zero:    inc = 1'b0;
        fp_norm_pkg::round_up:      inc = (sh[51] | (|sh[50:0])) & ~sign;
        default:                    inc = (sh[51] | (|sh[50:0])) & sign;
    endcase
    sum     = {1'b0, sh[104:52]} + 1'b1;
    carry   = inc & sum[fp_norm_pkg::FRACT_W];
    r.fract = !inc ? sh[104:52] : (carry ? sum[53:1] : sum[52:0]);
    r.exp   = ex + fp_norm_pkg::exp_t'(carry);
    r.ovf   = (lz == 0 && e >= fp_norm_pkg::EXP_MAX) || (carry && ex >= fp_norm_pkg::EXP_MAX);
    r.inf   = r.ovf && (mode == fp_norm_pkg::round_nearest ||
                        (mode == fp_norm_pkg::round_up && !sign) ||
                        (mode == fp_norm_pkg::round_down && sign));
    if (r.ovf)
    begin
        r.fract = r.inf ? '0 : '1;
        r.exp   = r.inf ? fp_norm_pkg::EXP_INF : fp_norm_pkg::EXP_MAX;
    end
    r.ine = sh[51] | (|sh[50:0]) | r.ovf;
    return r;
endfunction

`endif

// File: tests/norm_rnd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module norm_rnd_tb;
    import fp_norm_pkg::*;

    `include "norm_rnd_model.svh"

    localparam int RANDOM_OPS  = 300;
    localparam int DRAIN_LIMIT = 20;   // Cycles

    localparam raw_fract_t HIDDEN = raw_fract_t'(1) << 104;
    localparam raw_fract_t LSB    = raw_fract_t'(1) << 52;
    localparam raw_fract_t GUARD  = raw_fract_t'(1) << 51;
    localparam raw_fract_t ONES   = ((raw_fract_t'(1) << 53) - 1'b1) << 52;  // Bits 104..52

    logic       clk = 1'b0;
    logic       reset;
    raw_fract_t fract_in;
    exp_t       exp_in;
    logic       sign;
    logic [1:0] r_mode;
    fract_t     fract_out;
    exp_t       exp_out;
    logic       dn_out;
    logic       ine_out;
    logic       overflow_out;
    logic       infinite_out;

    norm_rnd_result_t want;   // Model result for the inputs now applied
    logic check_en = 1'b0;
    int   errors   = 0;
    int   applied  = 1;       // Idle inputs at reset release count as one
    int   seen     = 0;
    int   seed     = 65;

    always #20 clk = ~clk;

    norm_rnd DUT
    (
        .clk          (clk),
        .reset        (reset),
        .fract_in     (fract_in),
        .exp_in       (exp_in),
        .sign         (sign),
        .r_mode       (r_mode),
        .fract_out    (fract_out),
        .exp_out      (exp_out),
        .dn_out       (dn_out),
        .ine_out      (ine_out),
        .overflow_out (overflow_out),
        .infinite_out (infinite_out)
    );

    always_comb
    begin
        want = model_norm_rnd(fract_in, exp_in, sign, round_mode_e'(r_mode));
    end

    always @(posedge clk)
    begin
        check_en <= !reset;   // Skips the first cycle after reset
        if (check_en)
            seen <= seen + 1;
    end

    ////////////////////////////////////////////////////////////
    // Output checks one cycle behind the inputs
    ////////////////////////////////////////////////////////////

    a_reset_zero: assert property (@(posedge clk) (!reset && !check_en) |->
        (fract_out == '0 && exp_out == '0 && !dn_out && !ine_out && !overflow_out
         && !infinite_out))
    else
    begin
        errors++;
        $display("outputs were not cleared in the first cycle after reset");
    end

    a_fract: assert property (@(posedge clk) disable iff (reset)
        check_en |-> fract_out == $past(want.fract))
    else
    begin
        errors++;
        $display("error fract_out expected %h actual %h", $past(want.fract), $sampled(fract_out));
    end

    a_exp: assert property (@(posedge clk) disable iff (reset)
        check_en |-> exp_out == $past(want.exp))
    else
    begin
        errors++;
        $display("error exp_out expected %h actual %h", $past(want.exp), $sampled(exp_out));
    end

    a_dn: assert property (@(posedge clk) disable iff (reset)
        check_en |-> dn_out == $past(want.dn))
    else
    begin
        errors++;
        $display("error dn_out expected %h actual %h", $past(want.dn), $sampled(dn_out));
    end

    a_ine: assert property (@(posedge clk) disable iff (reset)
        check_en |-> ine_out == $past(want.ine))
    else
    begin
        errors++;
        $display("error ine_out expected %h actual %h", $past(want.ine), $sampled(ine_out));
    end

    a_ovf: assert property (@(posedge clk) disable iff (reset)
        check_en |-> overflow_out == $past(want.ovf))
    else
    begin
        errors++;
        $display("error overflow_out expected %h actual %h", $past(want.ovf),
                 $sampled(overflow_out));
    end

    a_inf: assert property (@(posedge clk) disable iff (reset)
        check_en |-> infinite_out == $past(want.inf))
    else
    begin
        errors++;
        $display("error infinite_out expected %h actual %h", $past(want.inf),
                 $sampled(infinite_out));
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic apply_operand(input raw_fract_t f, input exp_t e, input logic s,
                                 input logic [1:0] m);
        @(posedge clk);
        fract_in <= f;
        exp_in   <= e;
        sign     <= s;
        r_mode   <= m;
        applied++;
    endtask

    // Same operand in all four modes and both signs
    task automatic sweep_modes(input raw_fract_t f, input exp_t e);
        for (int m = 0; m < 4; m++)
        begin
            for (int s = 0; s < 2; s++)
                apply_operand(f, e, s[0], m[1:0]);
        end
    endtask

    initial
    begin
        raw_fract_t f;
        int         wait_cycles;
        reset    = 1'b1;
        fract_in = '0;
        exp_in   = '0;
        sign     = 1'b0;
        r_mode   = 2'd0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Normalization paths
        apply_operand(raw_fract_t'(3) << 104, 11'd100, 1'b0, 2'd0);  // lz 0
        apply_operand(HIDDEN | GUARD, 11'd100, 1'b0, 2'd1);          // lz 1
        apply_operand(raw_fract_t'(5) << 93, 11'd100, 1'b1, 2'd0);   // lz 10
        apply_operand(raw_fract_t'(1) << 80, 11'd5, 1'b0, 2'd0);     // Denormal

        // Ties, exact and inexact values
        sweep_modes(HIDDEN | GUARD, 11'd1000);
        sweep_modes(HIDDEN | LSB | GUARD, 11'd1000);
        sweep_modes(HIDDEN | (raw_fract_t'(1) << 60), 11'd1000);
        sweep_modes(HIDDEN | raw_fract_t'(1), 11'd1000);
        sweep_modes(HIDDEN | GUARD | raw_fract_t'(1), 11'd1000);

        sweep_modes(ONES | GUARD, 11'd1000);   // Rounding carry-out

        // Overflow from the right shift and from the rounding carry
        sweep_modes(raw_fract_t'(1) << 105, EXP_MAX);
        sweep_modes(raw_fract_t'(1) << 105, EXP_INF);
        sweep_modes(ONES | GUARD | raw_fract_t'(1), EXP_MAX);

        // Back to back random operands
        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            f = raw_fract_t'({$random(seed), $random(seed), $random(seed), $random(seed)});
            f = f >> ($unsigned($random(seed)) % 107);
            apply_operand(f, exp_t'($random(seed)), 1'($random(seed)), 2'($random(seed)));
        end

        wait_cycles = 0;
        while (seen < applied && wait_cycles < DRAIN_LIMIT)
        begin
            @(posedge clk);
            wait_cycles++;
        end
        if (seen < applied)
        begin
            errors++;
            $display("timeout while waiting for the last results");
        end

        $display("%0d errors in %0d checked cycles", errors, seen);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hdl/fp_norm_pkg.sv
hdl/norm_bus.sv
hdl/lead_zero_count.sv
hdl/normalizer.sv
hdl/rounder.sv
hdl/norm_rnd.sv
tests/norm_rnd_tb.sv

// File: Makefile
TOP = norm_rnd_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir
